// File: include/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// integer register and datapath width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_REG_COUNT 32

// data memory depth in words
`define RV_DMEM_WORDS 256

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: hdl/rv_core_pkg.sv
package rv_core_pkg;

    // major opcodes handled by the core, anything else is a no-op
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_imm    = 7'b0010011, // op-imm
        opc_reg    = 7'b0110011  // op
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10 // lui
    } alu_op_t;

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_fmt_t;

    typedef enum logic {
        a_rs1,
        a_pc
    } a_sel_t;

    typedef enum logic [1:0] {
        b_rs2,
        b_imm,
        b_four // link value pc+4
    } b_sel_t;

    // encoded as the load funct3 so decode is a plain cast
    typedef enum logic [2:0] {
        lext_b  = 3'b000,
        lext_h  = 3'b001,
        lext_w  = 3'b010,
        lext_bu = 3'b100,
        lext_hu = 3'b101
    } load_ext_t;

endpackage

// File: hdl/control_unit.sv
`timescale 1ns/100ps

module control_unit (
    input  logic [6:0]              opcode,
    input  logic [2:0]              funct3,
    input  logic                    funct7_bit, // cmd[30]
    input  logic                    less,
    input  logic                    zero,
    output rv_core_pkg::imm_fmt_t   imm_fmt,
    output rv_core_pkg::a_sel_t     a_sel,
    output rv_core_pkg::b_sel_t     b_sel,
    output rv_core_pkg::alu_op_t    alu_op,
    output logic                    reg_wen,
    output logic                    load,
    output logic                    store,
    output rv_core_pkg::load_ext_t  load_ext,
    output logic [1:0]              store_size, // 0 byte, 1 half, 2 word
    output logic                    take_target,
    output logic                    target_from_rs1
);

    logic is_branch;
    logic is_jump;
    logic branch_cond;

    // funct3 to alu op for op and op-imm
    function automatic rv_core_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
            3'b001:  return rv_core_pkg::alu_sll;
            3'b010:  return rv_core_pkg::alu_slt;
            3'b011:  return rv_core_pkg::alu_sltu;
            3'b100:  return rv_core_pkg::alu_xor;
            3'b101:  return alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
            3'b110:  return rv_core_pkg::alu_or;
            default: return rv_core_pkg::alu_and;
        endcase
    endfunction

    always_comb begin
        imm_fmt         = rv_core_pkg::imm_i;
        a_sel           = rv_core_pkg::a_rs1;
        b_sel           = rv_core_pkg::b_rs2;
        alu_op          = rv_core_pkg::alu_add;
        reg_wen         = 1'b0;
        load            = 1'b0;
        store           = 1'b0;
        load_ext        = rv_core_pkg::load_ext_t'(funct3);
        store_size      = funct3[1:0];
        is_branch       = 1'b0;
        is_jump         = 1'b0;
        target_from_rs1 = 1'b0;
        case (opcode)
            rv_core_pkg::opc_lui: begin
                imm_fmt = rv_core_pkg::imm_u;
                b_sel   = rv_core_pkg::b_imm;
                alu_op  = rv_core_pkg::alu_pass_b; // upper imm straight through
                reg_wen = 1'b1;
            end
            rv_core_pkg::opc_auipc: begin
                imm_fmt = rv_core_pkg::imm_u;
                a_sel   = rv_core_pkg::a_pc;
                b_sel   = rv_core_pkg::b_imm;
                reg_wen = 1'b1;
            end
            rv_core_pkg::opc_jal, rv_core_pkg::opc_jalr: begin
                imm_fmt         = (opcode == rv_core_pkg::opc_jal) ? rv_core_pkg::imm_j
                                                                   : rv_core_pkg::imm_i;
                a_sel           = rv_core_pkg::a_pc; // link = pc + 4
                b_sel           = rv_core_pkg::b_four;
                reg_wen         = 1'b1;
                is_jump         = 1'b1;
                target_from_rs1 = (opcode == rv_core_pkg::opc_jalr);
            end
            rv_core_pkg::opc_branch: begin
                imm_fmt   = rv_core_pkg::imm_b;
                is_branch = (funct3[2:1] != 2'b01); // 010/011 undefined
                if (!funct3[2])
                    alu_op = rv_core_pkg::alu_sub; // beq/bne via zero
                else if (funct3[1])
                    alu_op = rv_core_pkg::alu_sltu;
                else
                    alu_op = rv_core_pkg::alu_slt;
            end
            rv_core_pkg::opc_load: begin
                b_sel   = rv_core_pkg::b_imm; // address = rs1 + imm
                load    = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
                reg_wen = load;
            end
            rv_core_pkg::opc_store: begin
                imm_fmt = rv_core_pkg::imm_s;
                b_sel   = rv_core_pkg::b_imm;
                store   = !funct3[2] && (funct3[1:0] != 2'b11);
            end
            rv_core_pkg::opc_imm: begin
                b_sel   = rv_core_pkg::b_imm;
                alu_op  = arith_op(funct3, funct7_bit && (funct3 == 3'b101)); // srai only
                reg_wen = 1'b1;
            end
            rv_core_pkg::opc_reg: begin
                alu_op  = arith_op(funct3, funct7_bit);
                reg_wen = 1'b1;
            end
            default: ; // unknown opcode, nothing written
        endcase
    end

    // branch outcome kept apart from decode so less/zero never feed alu_op
    assign branch_cond = funct3[2] ? (less ^ funct3[0]) : (zero ^ funct3[0]);
    assign take_target = is_jump || (is_branch && branch_cond);

    always_comb begin
        assert (!(load && store))
            else $error("control_unit: load and store both set for opcode %b", opcode);
    end

endmodule

// File: hdl/imm_decoder.sv
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module imm_decoder (
    input  logic [31:0]            cmd,
    input  rv_core_pkg::imm_fmt_t  imm_fmt,
    output logic [`RV_XLEN-1:0]    imm
);

    logic sign;

    assign sign = cmd[31]; // every format takes sign from bit 31

    always_comb begin
        case (imm_fmt)
            rv_core_pkg::imm_s:
                imm = {{21{sign}}, cmd[30:25], cmd[11:7]};
            rv_core_pkg::imm_b: // bit 0 always zero
                imm = {{20{sign}}, cmd[7], cmd[30:25], cmd[11:8], 1'b0};
            rv_core_pkg::imm_u: // low 12 bits zero
                imm = {cmd[31:12], 12'b0};
            rv_core_pkg::imm_j:
                imm = {{12{sign}}, cmd[19:12], cmd[20], cmd[30:21], 1'b0};
            default: // i format, also loads and jalr
                imm = {{21{sign}}, cmd[30:20]};
        endcase
    end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module register_file (
    input  logic                              clk,
    input  logic [$clog2(`RV_REG_COUNT)-1:0]  raddr_a,
    input  logic [$clog2(`RV_REG_COUNT)-1:0]  raddr_b,
    input  logic [$clog2(`RV_REG_COUNT)-1:0]  waddr,
    input  logic [`RV_XLEN-1:0]               wdata,
    input  logic                              wen,
    output logic [`RV_XLEN-1:0]               rdata_a,
    output logic [`RV_XLEN-1:0]               rdata_b
);

    // entry 0 is never written, reads of x0 are muxed to zero
    logic [`RV_XLEN-1:0] regs [0:`RV_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (wen && (waddr != '0))
            regs[waddr] <= wdata; // visible next cycle
    end

    // combinational reads, no write bypass needed in single cycle
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    a_x0_reads_zero: assert property (
        @(posedge clk) ((raddr_a == '0) |-> (rdata_a == '0)) and
                       ((raddr_b == '0) |-> (rdata_b == '0))
    ) else $error("register_file: x0 read back nonzero");

endmodule

// File: hdl/alu.sv
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module alu (
    input  rv_core_pkg::alu_op_t  alu_op,
    input  logic [`RV_XLEN-1:0]   a,
    input  logic [`RV_XLEN-1:0]   b,
    output logic [`RV_XLEN-1:0]   result,
    output logic                  less,
    output logic                  zero
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0]; // shifts use low five bits only
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    // sltu picks unsigned, everything else reports the signed compare
    assign less = (alu_op == rv_core_pkg::alu_sltu) ? lt_unsigned : lt_signed;

    always_comb begin
        case (alu_op)
            rv_core_pkg::alu_add:    result = a + b;
            rv_core_pkg::alu_sub:    result = a - b;
            rv_core_pkg::alu_sll:    result = a << shamt;
            rv_core_pkg::alu_slt,
            rv_core_pkg::alu_sltu:   result = {{(`RV_XLEN-1){1'b0}}, less};
            rv_core_pkg::alu_xor:    result = a ^ b;
            rv_core_pkg::alu_srl:    result = a >> shamt;
            rv_core_pkg::alu_sra:    result = `RV_XLEN'($signed(a) >>> shamt);
            rv_core_pkg::alu_or:     result = a | b;
            rv_core_pkg::alu_and:    result = a & b;
            rv_core_pkg::alu_pass_b: result = b;
            default:                 result = a + b;
        endcase
    end

    // on sub this is the beq/bne equality test
    assign zero = (result == '0);

endmodule

// File: hdl/data_memory.sv
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module data_memory (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`RV_XLEN-1:0]      addr,
    input  logic [`RV_XLEN-1:0]      wdata,
    input  logic                     store,
    input  logic [1:0]               store_size, // 0 byte, 1 half, 2 word
    input  rv_core_pkg::load_ext_t   load_ext,
    output logic [`RV_XLEN-1:0]      rdata,
    output logic [`RV_XLEN/8-1:0]    wmask,
    output logic [`RV_XLEN-1:0]      wdata_aligned
);

    localparam int idx_w = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0]   mem [0:`RV_DMEM_WORDS-1];
    logic [idx_w-1:0]      idx;
    logic [`RV_XLEN-1:0]   word_rd;
    logic [7:0]            byte_rd;
    logic [15:0]           half_rd;
    logic [`RV_XLEN/8-1:0] lane_mask;

    assign idx = addr[idx_w+1:2]; // wraps modulo depth

    // lane placement for stores
    always_comb begin
        case (store_size)
            2'd0: begin
                lane_mask     = 4'b0001 << addr[1:0];
                wdata_aligned = `RV_XLEN'(wdata[7:0]) << {addr[1:0], 3'b000};
            end
            2'd1: begin // only addr[1] picks the half
                lane_mask     = 4'b0011 << {addr[1], 1'b0};
                wdata_aligned = `RV_XLEN'(wdata[15:0]) << {addr[1], 4'b0000};
            end
            default: begin
                lane_mask     = 4'b1111;
                wdata_aligned = wdata;
            end
        endcase
    end

    assign wmask = store ? lane_mask : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++)
                mem[i] <= '0;
        end else if (store) begin
            for (int b = 0; b < `RV_XLEN/8; b++) begin
                if (lane_mask[b])
                    mem[idx][8*b +: 8] <= wdata_aligned[8*b +: 8];
            end
        end
    end

    // combinational load path
    assign word_rd = mem[idx];
    assign byte_rd = word_rd[{addr[1:0], 3'b000} +: 8];
    assign half_rd = word_rd[{addr[1], 4'b0000} +: 16];

    always_comb begin
        case (load_ext)
            rv_core_pkg::lext_b:  rdata = {{24{byte_rd[7]}}, byte_rd};
            rv_core_pkg::lext_h:  rdata = {{16{half_rd[15]}}, half_rd};
            rv_core_pkg::lext_bu: rdata = {24'b0, byte_rd};
            rv_core_pkg::lext_hu: rdata = {16'b0, half_rd};
            default:              rdata = word_rd; // lw
        endcase
    end

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           cmd,
    output logic [`RV_XLEN-1:0]   pc,
    output logic [`RV_XLEN-1:0]   dnpc,
    output logic                  rd_wen,
    output logic [4:0]            rd_addr,
    output logic [`RV_XLEN-1:0]   rd_data,
    output logic                  mem_wen,
    output logic [`RV_XLEN-1:0]   mem_addr,
    output logic [`RV_XLEN-1:0]   mem_wdata,
    output logic [3:0]            mem_wmask
);

    rv_core_pkg::imm_fmt_t  imm_fmt;
    rv_core_pkg::a_sel_t    a_sel;
    rv_core_pkg::b_sel_t    b_sel;
    rv_core_pkg::alu_op_t   alu_op;
    rv_core_pkg::load_ext_t load_ext;
    logic                   reg_wen, load, store;
    logic [1:0]             store_size;
    logic                   take_target, target_from_rs1;
    logic                   less, zero;

    logic [`RV_XLEN-1:0] imm, rs1_data, rs2_data;
    logic [`RV_XLEN-1:0] alu_a, alu_b, alu_result, load_data;
    logic [`RV_XLEN-1:0] target_sum, target;

    control_unit control_unit_i (
        .opcode(cmd[6:0]), .funct3(cmd[14:12]), .funct7_bit(cmd[30]),
        .less(less), .zero(zero),
        .imm_fmt(imm_fmt), .a_sel(a_sel), .b_sel(b_sel), .alu_op(alu_op),
        .reg_wen(reg_wen), .load(load), .store(store),
        .load_ext(load_ext), .store_size(store_size),
        .take_target(take_target), .target_from_rs1(target_from_rs1)
    );

    imm_decoder imm_decoder_i (.cmd(cmd), .imm_fmt(imm_fmt), .imm(imm));

    register_file register_file_i (
        .clk(clk),
        .raddr_a(cmd[19:15]), .raddr_b(cmd[24:20]),
        .waddr(rd_addr), .wdata(rd_data), .wen(rd_wen),
        .rdata_a(rs1_data), .rdata_b(rs2_data)
    );

    // operand muxes
    assign alu_a = (a_sel == rv_core_pkg::a_pc) ? pc : rs1_data;
    always_comb begin
        case (b_sel)
            rv_core_pkg::b_imm:  alu_b = imm;
            rv_core_pkg::b_four: alu_b = `RV_XLEN'(4);
            default:             alu_b = rs2_data;
        endcase
    end

    alu alu_i (
        .alu_op(alu_op), .a(alu_a), .b(alu_b),
        .result(alu_result), .less(less), .zero(zero)
    );

    data_memory data_memory_i (
        .clk(clk), .reset(reset),
        .addr(alu_result), .wdata(rs2_data),
        .store(mem_wen), .store_size(store_size), .load_ext(load_ext),
        .rdata(load_data), .wmask(mem_wmask), .wdata_aligned(mem_wdata)
    );

    // separate target adder, alu is busy with link or compare
    assign target_sum = (target_from_rs1 ? rs1_data : pc) + imm;
    assign target     = target_from_rs1 ? {target_sum[`RV_XLEN-1:1], 1'b0} : target_sum;
    assign dnpc       = take_target ? target : pc + `RV_XLEN'(4);

    always_ff @(posedge clk) begin
        if (reset)
            pc <= `RV_RESET_PC;
        else
            pc <= dnpc;
    end

    // writeback and store strobes held off during reset
    assign rd_addr  = cmd[11:7];
    assign rd_data  = load ? load_data : alu_result;
    assign rd_wen   = reg_wen && !reset;
    assign mem_wen  = store && !reset;
    assign mem_addr = {alu_result[`RV_XLEN-1:2], 2'b00}; // word aligned

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
    ) else $error("rv_core: misaligned pc %h", pc);

endmodule

// File: verification/rv_core_checker.sv
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module rv_core_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] cmd,
    input  logic [31:0] pc,
    input  logic [31:0] dnpc,
    input  logic        rd_wen,
    input  logic [4:0]  rd_addr,
    input  logic [31:0] rd_data,
    input  logic        mem_wen,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    input  logic [3:0]  mem_wmask,
    output int          error_count,
    output int          check_count
);

    logic [31:0] regs [0:31];                  // reference register file
    logic [31:0] mem [0:`RV_DMEM_WORDS-1];     // reference data memory
    logic [31:0] model_pc;

    initial begin
        error_count = 0;
        check_count = 0;
        model_pc    = `RV_RESET_PC;
        for (int i = 0; i < 32; i++)
            regs[i] = 32'h0;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s got %h expected %h (pc %h cmd %h)", name, got, exp,
                     model_pc, cmd);
        end
    endtask

    // one instruction of the ISA, checked against the DUT ports then committed
    task automatic execute_and_check();
        logic [4:0]  rs1, rs2, rd, sh;
        logic [2:0]  f3;
        logic [31:0] a, b, ii, si, bi, ui, ji, npc, wd, addr, word, sdata;
        logic [3:0]  mask;
        logic        wen, mwen, taken;
        rs1   = cmd[19:15];
        rs2   = cmd[24:20];
        rd    = cmd[11:7];
        f3    = cmd[14:12];
        a     = (rs1 == 5'd0) ? 32'h0 : regs[rs1];
        b     = (rs2 == 5'd0) ? 32'h0 : regs[rs2];
        ii    = {{20{cmd[31]}}, cmd[31:20]};
        si    = {{20{cmd[31]}}, cmd[31:25], cmd[11:7]};
        bi    = {{19{cmd[31]}}, cmd[31], cmd[7], cmd[30:25], cmd[11:8], 1'b0};
        ui    = {cmd[31:12], 12'h000};
        ji    = {{11{cmd[31]}}, cmd[31], cmd[19:12], cmd[20], cmd[30:21], 1'b0};
        npc   = model_pc + 32'd4;
        wd    = 32'h0;
        wen   = 1'b0;
        mwen  = 1'b0;
        mask  = 4'h0;
        sdata = 32'h0;
        addr  = 32'h0;
        taken = 1'b0;
        case (cmd[6:0])
            rv_core_pkg::opc_lui: begin
                wen = 1'b1;
                wd  = ui;
            end
            rv_core_pkg::opc_auipc: begin
                wen = 1'b1;
                wd  = model_pc + ui;
            end
            rv_core_pkg::opc_jal: begin
                wen = 1'b1;
                wd  = model_pc + 32'd4; // link
                npc = model_pc + ji;
            end
            rv_core_pkg::opc_jalr: begin
                wen = 1'b1;
                wd  = model_pc + 32'd4;
                npc = (a + ii) & 32'hffff_fffe;
            end
            rv_core_pkg::opc_branch: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = !($signed(a) < $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = !(a < b);
                    default: taken = 1'b0;
                endcase
                if (taken)
                    npc = model_pc + bi;
            end
            rv_core_pkg::opc_load: begin
                addr = a + ii;
                word = mem[addr[9:2]];
                wen  = 1'b1;
                case (f3)
                    3'b000:  wd = {{24{word[8*addr[1:0]+7]}}, word[8*addr[1:0] +: 8]};
                    3'b001:  wd = {{16{word[16*addr[1]+15]}}, word[16*addr[1] +: 16]};
                    3'b100:  wd = {24'h0, word[8*addr[1:0] +: 8]};
                    3'b101:  wd = {16'h0, word[16*addr[1] +: 16]};
                    default: wd = word; // lw
                endcase
            end
            rv_core_pkg::opc_store: begin
                addr = a + si;
                mwen = 1'b1;
                case (f3)
                    3'b000: begin
                        mask  = 4'b0001 << addr[1:0];
                        sdata = {24'h0, b[7:0]} << (8 * addr[1:0]);
                    end
                    3'b001: begin // half lane from addr[1] only
                        mask  = addr[1] ? 4'b1100 : 4'b0011;
                        sdata = {16'h0, b[15:0]} << (16 * addr[1]);
                    end
                    default: begin
                        mask  = 4'b1111;
                        sdata = b;
                    end
                endcase
            end
            rv_core_pkg::opc_imm, rv_core_pkg::opc_reg: begin
                if (cmd[6:0] == rv_core_pkg::opc_imm)
                    b = ii; // second operand is the immediate
                sh  = b[4:0];
                wen = 1'b1;
                case (f3)
                    3'b000: wd = (cmd[5] && cmd[30]) ? a - b : a + b; // sub only in op
                    3'b001: wd = a << sh;
                    3'b010: wd = {31'h0, $signed(a) < $signed(b)};
                    3'b011: wd = {31'h0, a < b};
                    3'b100: wd = a ^ b;
                    3'b101: wd = cmd[30] ? 32'($signed(a) >>> sh) : a >> sh;
                    3'b110: wd = a | b;
                    default: wd = a & b;
                endcase
            end
            default: ; // unknown opcode, nothing written
        endcase

        compare_value("pc", pc, model_pc);
        compare_value("dnpc", dnpc, npc);
        compare_value("rd_wen", {31'h0, rd_wen}, {31'h0, wen});
        if (wen) begin
            compare_value("rd_addr", {27'h0, rd_addr}, {27'h0, rd});
            compare_value("rd_data", rd_data, wd);
        end
        compare_value("mem_wen", {31'h0, mem_wen}, {31'h0, mwen});
        if (mwen) begin
            compare_value("mem_addr", mem_addr, addr & 32'hffff_fffc);
            compare_value("mem_wdata", mem_wdata, sdata);
            compare_value("mem_wmask", {28'h0, mem_wmask}, {28'h0, mask});
        end

        // commit model state
        if (wen && rd != 5'd0)
            regs[rd] = wd;
        for (int i = 0; i < 4; i++) begin
            if (mwen && mask[i])
                mem[addr[9:2]][8*i +: 8] = sdata[8*i +: 8];
        end
        model_pc = npc;
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (reset) begin
            compare_value("rd_wen", {31'h0, rd_wen}, 32'h0);
            compare_value("mem_wen", {31'h0, mem_wen}, 32'h0);
            model_pc = `RV_RESET_PC;
            for (int i = 0; i < `RV_DMEM_WORDS; i++)
                mem[i] = 32'h0;
        end else begin
            execute_and_check();
        end
    end

endmodule

// File: include/rv_core_tb_cfg.svh
`ifndef RV_CORE_TB_CFG_SVH
`define RV_CORE_TB_CFG_SVH

// cycles run after reset is released
`define TB_RUN_CYCLES 2000

// reset length in clock cycles
`define TB_RESET_CYCLES 2

// clock period in ns
`define TB_CLK_PERIOD 20

`endif

// File: verification/rv_core_tb.sv
`timescale 1ns/100ps
`include "rv_core_cfg.svh"
`include "rv_core_tb_cfg.svh"

module rv_core_tb;

    logic        clk;
    logic        reset;
    logic [31:0] cmd;
    logic [31:0] pc, dnpc, rd_data, mem_addr, mem_wdata;
    logic        rd_wen, mem_wen;
    logic [4:0]  rd_addr;
    logic [3:0]  mem_wmask;
    int          error_count, check_count;

    logic [31:0] prog [0:255];
    logic [31:0] lcg_state;

    rv_core rv_core_i (
        .clk(clk), .reset(reset), .cmd(cmd),
        .pc(pc), .dnpc(dnpc),
        .rd_wen(rd_wen), .rd_addr(rd_addr), .rd_data(rd_data),
        .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wmask(mem_wmask)
    );

    rv_core_checker checker_i (
        .clk(clk), .reset(reset), .cmd(cmd),
        .pc(pc), .dnpc(dnpc),
        .rd_wen(rd_wen), .rd_addr(rd_addr), .rd_data(rd_data),
        .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_wmask(mem_wmask),
        .error_count(error_count), .check_count(check_count)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // random kept instruction, or an unknown opcode about one time in twenty
    function automatic logic [31:0] random_instr();
        logic [31:0] r, s, off;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        int          w;
        r   = next_rand();
        s   = next_rand();
        rd  = s[4:0];
        rs1 = s[9:5];
        rs2 = s[14:10];
        w   = int'(s[23:16] % 8'd129) - 64; // branch/jump reach in words
        if (w == 0)
            w = 1;
        off = 32'(w * 4);
        case (r[31:16] % 16'd20)
            0: begin
                case (s[31:30])
                    2'd0: return {s[31:7], 7'b0001111};
                    2'd1: return {s[31:7], 7'b1110011};
                    2'd2: return {s[31:7], 7'b0101111};
                    default: return {s[31:7], 7'b1010011};
                endcase
            end
            1: return {r[11:0], s[31:24], rd, 7'b0110111}; // lui
            2: return {r[11:0], s[31:24], rd, 7'b0010111}; // auipc
            3: return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            4: return {2'b00, s[31:24], 2'b00, 5'd0, 3'b000, rd, 7'b1100111}; // jalr off x0
            5, 6: begin
                case (s[26:24] % 3'd6)
                    3'd0: f3 = 3'b000;
                    3'd1: f3 = 3'b001;
                    3'd2: f3 = 3'b100;
                    3'd3: f3 = 3'b101;
                    3'd4: f3 = 3'b110;
                    default: f3 = 3'b111;
                endcase
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
            end
            7, 8, 9: begin
                case (s[26:24] % 3'd5)
                    3'd0: f3 = 3'b000;
                    3'd1: f3 = 3'b001;
                    3'd2: f3 = 3'b010;
                    3'd3: f3 = 3'b100;
                    default: f3 = 3'b101;
                endcase
                if (s[27]) // small x0-based addresses so loads hit earlier stores
                    return {6'h00, r[5:0], 5'd0, f3, rd, 7'b0000011};
                return {r[11:0], rs1, f3, rd, 7'b0000011};
            end
            10, 11: begin
                f3 = {1'b0, (s[25:24] == 2'd3) ? 2'd2 : s[25:24]};
                if (s[27])
                    return {6'h00, r[5], rs2, 5'd0, f3, r[4:0], 7'b0100011};
                return {r[11:5], rs2, rs1, f3, r[4:0], 7'b0100011};
            end
            12, 13, 14, 15: begin
                f3 = s[26:24];
                if (f3 == 3'b001 || f3 == 3'b101) // shifts take a legal funct7
                    return {1'b0, r[0] && (f3 == 3'b101), 5'b00000,
                            r[5:1], rs1, f3, rd, 7'b0010011};
                return {r[11:0], rs1, f3, rd, 7'b0010011};
            end
            default: begin
                f3 = s[26:24];
                return {1'b0, r[0] && (f3 == 3'b000 || f3 == 3'b101), 5'b00000,
                        rs2, rs1, f3, rd, 7'b0110011};
            end
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #(`TB_CLK_PERIOD / 2) clk = ~clk;
    end

    // next word fetched shortly after each edge
    always @(posedge clk) begin
        #1 cmd = prog[pc[9:2]];
    end

    initial begin
        #((`TB_RESET_CYCLES + `TB_RUN_CYCLES) * `TB_CLK_PERIOD * 2);
        $display("timeout: run went past its expected length without finishing");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        reset     = 1'b1;
        cmd       = 32'h0000_0013; // addi x0, x0, 0
        lcg_state = 32'h83d3_36d5;
        for (int i = 1; i < 32; i++) begin // prologue defines x1..x31
            r           = next_rand();
            prog[i - 1] = {r[31:20], 5'd0, 3'b000, 5'(i), 7'b0010011};
        end
        for (int i = 31; i < 256; i++)
            prog[i] = random_instr();

        repeat (`TB_RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        repeat (`TB_RUN_CYCLES) @(posedge clk);
        @(negedge clk);
        #1;
        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
hdl/rv_core_pkg.sv
hdl/control_unit.sv
hdl/imm_decoder.sv
hdl/register_file.sv
hdl/alu.sv
hdl/data_memory.sv
hdl/rv_core.sv
verification/rv_core_checker.sv
verification/rv_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f verilog.f --top-module rv_core_tb -o rv_core_sim > build.log 2>&1 \
    && ./obj_dir/rv_core_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
